// ==== src/des_pkg.sv ====
`default_nettype none

package des_pkg;

  typedef logic [63:0] block_t;
  typedef logic [31:0] half_t;
  typedef logic [47:0] subkey_t;
  typedef logic [27:0] key_half_t;
  typedef logic [4:0]  round_t;

  typedef struct packed {
    half_t l;
    half_t r;
  } lr_t;

  typedef struct packed {
    block_t message;
    block_t key;
  } ofb_req_t;

  localparam int NUM_ROUNDS = 16;

  // all tables use FIPS 46 numbering, bit 1 is the msb
  localparam int IP_TABLE [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

  localparam int FP_TABLE [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

  localparam int E_TABLE [48] = '{
    32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

  localparam int P_TABLE [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};

  // first 28 entries feed C, the rest feed D
  localparam int PC1_TABLE [56] = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
    10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
    14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};

  localparam int PC2_TABLE [48] = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
    26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

  // left shift per encryption round, round 1 first
  localparam int SHIFT_TABLE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

  // indexed by {row, column}, row taken from the outer bits of the group
  localparam int SBOX_TABLE [8][64] = '{
    '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
      0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
      4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
      15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
    '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
      3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
      0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
      13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
    '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
      13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
      13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
      1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
    '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
      13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
      10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
      3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
    '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
      14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
      4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
      11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
    '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
      10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
      9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
      4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
    '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
      13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
      1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
      6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
    '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
      1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
      7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
      2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}};

endpackage

`default_nettype wire

// ==== src/des_f_function.sv ====
`default_nettype none
`timescale 1ns/100ps

module des_f_function (
  input  des_pkg::half_t   r,
  input  des_pkg::subkey_t subkey,
  output des_pkg::half_t   f_out
);

  logic [47:0]    expanded;
  logic [47:0]    mixed;
  logic [5:0]     group [8];
  des_pkg::half_t sbox_out;

  // expansion to 48 bits
  always_comb
  begin
    for (int i = 0; i < 48; i++)
      expanded[47 - i] = r[32 - des_pkg::E_TABLE[i]];
  end

  assign mixed = expanded ^ subkey;

  // group 0 is the top six bits and goes to S1
  always_comb
  begin
    for (int b = 0; b < 8; b++)
    begin
      group[b] = mixed[47 - 6 * b -: 6];
      sbox_out[31 - 4 * b -: 4] =
        4'(des_pkg::SBOX_TABLE[b][{group[b][5], group[b][0], group[b][4:1]}]);
    end
  end

  always_comb
  begin
    for (int i = 0; i < 32; i++)
      f_out[31 - i] = sbox_out[32 - des_pkg::P_TABLE[i]];
  end

endmodule

`default_nettype wire

// ==== src/des_key_schedule.sv ====
`default_nettype none
`timescale 1ns/100ps

module des_key_schedule (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  des_pkg::block_t   key,
  input  des_pkg::round_t   round,
  output des_pkg::subkey_t  subkey
);

  des_pkg::key_half_t c;
  des_pkg::key_half_t d;
  logic [55:0]        pc1_out;
  logic [55:0]        cd;
  logic               rot2;

  always_comb
  begin
    for (int i = 0; i < 56; i++)
      pc1_out[55 - i] = key[64 - des_pkg::PC1_TABLE[i]];
  end

  assign cd = {c, d};

  always_comb
  begin
    for (int i = 0; i < 48; i++)
      subkey[47 - i] = cd[56 - des_pkg::PC2_TABLE[i]];
  end

  // undo the shift of the round being unwound, last round first
  assign rot2 = des_pkg::SHIFT_TABLE[4'(des_pkg::NUM_ROUNDS - 1) - round[3:0]] == 2;

  // PC-1 output equals C16/D16, since the total left shift is 28
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      c <= '0;
      d <= '0;
    end
    else if (load)
    begin
      c <= pc1_out[55:28];
      d <= pc1_out[27:0];
    end
    else if (round < 5'(des_pkg::NUM_ROUNDS))
    begin
      if (rot2)
      begin
        c <= {c[1:0], c[27:2]};
        d <= {d[1:0], d[27:2]};
      end
      else
      begin
        c <= {c[0], c[27:1]};
        d <= {d[0], d[27:1]};
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/des_round_engine.sv ====
`default_nettype none
`timescale 1ns/100ps

module des_round_engine (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             engine_start,
  input  des_pkg::block_t  engine_block,
  input  des_pkg::block_t  engine_key,
  output des_pkg::block_t  keystream,
  output logic             engine_done
);

  des_pkg::lr_t     lr;
  des_pkg::round_t  round;
  logic             active;
  logic             last;
  des_pkg::block_t  ip_out;
  des_pkg::block_t  swapped;
  des_pkg::subkey_t subkey;
  des_pkg::half_t   f_out;

  des_key_schedule u_key_schedule (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (engine_start),
    .key    (engine_key),
    .round  (round),
    .subkey (subkey)
  );

  des_f_function u_f_function (
    .r      (lr.r),
    .subkey (subkey),
    .f_out  (f_out)
  );

  always_comb
  begin
    for (int i = 0; i < 64; i++)
      ip_out[63 - i] = engine_block[64 - des_pkg::IP_TABLE[i]];
  end

  // R16 L16 order before the final permutation
  assign swapped = {lr.r, lr.l};

  always_comb
  begin
    for (int i = 0; i < 64; i++)
      keystream[63 - i] = swapped[64 - des_pkg::FP_TABLE[i]];
  end

  assign last        = round == 5'(des_pkg::NUM_ROUNDS);
  assign engine_done = active && last;

  // idle parks the counter at the last round so the key schedule holds still
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      round  <= 5'(des_pkg::NUM_ROUNDS);
    end
    else if (engine_start)
    begin
      active <= 1'b1;
      round  <= '0;
    end
    else if (engine_done)
    begin
      active <= 1'b0;
    end
    else if (active)
    begin
      round <= round + 5'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (engine_start)
      lr <= ip_out;
    else if (active && !last)
    begin
      lr.l <= lr.r;
      lr.r <= lr.l ^ f_out;
    end
  end

  // a new block must not restart the rounds of one in flight
  a_start_only_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) engine_start |-> !active);

endmodule

`default_nettype wire

// ==== src/ofb_input_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module ofb_input_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  des_pkg::ofb_req_t req,
  input  logic              load_iv,
  input  des_pkg::block_t   iv,
  input  logic              engine_done,
  input  des_pkg::block_t   keystream,
  output logic              engine_start,
  output des_pkg::block_t   engine_block,
  output des_pkg::block_t   engine_key,
  output des_pkg::block_t   held_message
);

  logic              busy;
  logic              accept_iv;
  logic              accept_start;
  des_pkg::block_t   feedback;
  des_pkg::ofb_req_t req_q;

  // an iv load wins over a start in the same idle cycle
  assign accept_iv    = load_iv && !busy;
  assign accept_start = start && !busy && !load_iv;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy         <= 1'b0;
      engine_start <= 1'b0;
      feedback     <= '0;
    end
    else
    begin
      engine_start <= accept_start;
      if (accept_start)
        busy <= 1'b1;
      else if (engine_done)
        busy <= 1'b0;
      // keystream of the finished block chains into the next one
      if (accept_iv)
        feedback <= iv;
      else if (engine_done)
        feedback <= keystream;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept_start)
      req_q <= req;
  end

  assign engine_block = feedback;
  assign engine_key   = req_q.key;
  assign held_message = req_q.message;

  a_done_only_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n) engine_done |-> busy);

endmodule

`default_nettype wire

// ==== src/ofb_output_stage.sv ====
`default_nettype none
`timescale 1ns/100ps

module ofb_output_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            engine_done,
  input  des_pkg::block_t keystream,
  input  des_pkg::block_t held_message,
  output des_pkg::block_t ciphertext,
  output logic            ct_valid
);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ct_valid   <= 1'b0;
      ciphertext <= '0;
    end
    else
    begin
      ct_valid <= engine_done;
      // message is held by the input stage until the block ends
      if (engine_done)
        ciphertext <= held_message ^ keystream;
    end
  end

  a_valid_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) ct_valid |=> !ct_valid);

endmodule

`default_nettype wire

// ==== src/ofb_des_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module ofb_des_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  des_pkg::ofb_req_t req,
  input  logic              load_iv,
  input  des_pkg::block_t   iv,
  output des_pkg::block_t   ciphertext,
  output logic              ct_valid
);

  logic            engine_start;
  logic            engine_done;
  des_pkg::block_t engine_block;
  des_pkg::block_t engine_key;
  des_pkg::block_t held_message;
  des_pkg::block_t keystream;

  ofb_input_stage u_input_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .req          (req),
    .load_iv      (load_iv),
    .iv           (iv),
    .engine_done  (engine_done),
    .keystream    (keystream),
    .engine_start (engine_start),
    .engine_block (engine_block),
    .engine_key   (engine_key),
    .held_message (held_message)
  );

  des_round_engine u_round_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .engine_start (engine_start),
    .engine_block (engine_block),
    .engine_key   (engine_key),
    .keystream    (keystream),
    .engine_done  (engine_done)
  );

  ofb_output_stage u_output_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .engine_done  (engine_done),
    .keystream    (keystream),
    .held_message (held_message),
    .ciphertext   (ciphertext),
    .ct_valid     (ct_valid)
  );

endmodule

`default_nettype wire

// ==== dv/ofb_des_ref.svh ====
`ifndef OFB_DES_REF_SVH
`define OFB_DES_REF_SVH

// DES round function as described in FIPS 46
function automatic des_pkg::half_t ref_feistel(input des_pkg::half_t r,
                                               input des_pkg::subkey_t k);
  logic [47:0]    x;
  logic [5:0]     g;
  int             row;
  int             col;
  des_pkg::half_t s;
  des_pkg::half_t p;
  for (int i = 0; i < 48; i++)
    x[47 - i] = r[32 - des_pkg::E_TABLE[i]];
  x = x ^ k;
  for (int b = 0; b < 8; b++)
  begin
    g   = x[47 - 6 * b -: 6];
    row = int'({g[5], g[0]});
    col = int'(g[4:1]);
    s[31 - 4 * b -: 4] = 4'(des_pkg::SBOX_TABLE[b][row * 16 + col]);
  end
  for (int i = 0; i < 32; i++)
    p[31 - i] = s[32 - des_pkg::P_TABLE[i]];
  return p;
endfunction

// keystream is the feedback run through DES with K16 first, i.e. a decryption
function automatic void ref_ofb_block(
  input  des_pkg::block_t feedback,
  input  des_pkg::block_t key,
  input  des_pkg::block_t message,
  output des_pkg::block_t keystream,
  output des_pkg::block_t ciphertext
);
  logic [27:0]      c;
  logic [27:0]      d;
  logic [55:0]      cd;
  des_pkg::subkey_t ks [16];
  des_pkg::block_t  perm;
  des_pkg::block_t  pre;
  des_pkg::half_t   l;
  des_pkg::half_t   r;
  des_pkg::half_t   t;
  for (int i = 0; i < 56; i++)
    cd[55 - i] = key[64 - des_pkg::PC1_TABLE[i]];
  c = cd[55:28];
  d = cd[27:0];
  // forward schedule with left rotations, K1 first
  for (int n = 0; n < 16; n++)
  begin
    for (int s = 0; s < des_pkg::SHIFT_TABLE[n]; s++)
    begin
      c = {c[26:0], c[27]};
      d = {d[26:0], d[27]};
    end
    cd = {c, d};
    for (int i = 0; i < 48; i++)
      ks[n][47 - i] = cd[56 - des_pkg::PC2_TABLE[i]];
  end
  for (int i = 0; i < 64; i++)
    perm[63 - i] = feedback[64 - des_pkg::IP_TABLE[i]];
  l = perm[63:32];
  r = perm[31:0];
  for (int n = 15; n >= 0; n--)
  begin
    t = r;
    r = l ^ ref_feistel(r, ks[n]);
    l = t;
  end
  pre = {r, l};
  for (int i = 0; i < 64; i++)
    keystream[63 - i] = pre[64 - des_pkg::FP_TABLE[i]];
  ciphertext = message ^ keystream;
endfunction

`endif

// ==== dv/ofb_des_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module ofb_des_tb;

  `include "ofb_des_ref.svh"

  localparam int NUM_BLOCKS     = 35;
  localparam int TIMEOUT_CYCLES = 2 * (NUM_BLOCKS * 20 + 100);
  localparam int LATENCY        = 18;
  localparam des_pkg::block_t KAT_KEY = 64'h1334_5779_9bbc_dff1;

  logic              clk;
  logic              rst_n;
  logic              start;
  des_pkg::ofb_req_t req;
  logic              load_iv;
  des_pkg::block_t   iv;
  des_pkg::block_t   ciphertext;
  logic              ct_valid;

  des_pkg::block_t   model_fb;
  des_pkg::block_t   exp_ct_q [$];
  int                exp_edge_q [$];
  int                cycle;
  int                errors;
  int                tests_passed;
  int                tests_failed;
  logic              valid_seen;

  ofb_des_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .req        (req),
    .load_iv    (load_iv),
    .iv         (iv),
    .ciphertext (ciphertext),
    .ct_valid   (ct_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a block never completed", cycle);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic report_failure(input string msg);
    $display("%0t %s", $time, msg);
    errors++;
  endtask

  // outputs are looked at mid-cycle, away from the clock edge
  always @(negedge clk)
  begin : check_outputs
    des_pkg::block_t exp_ct;
    int              exp_edge;
    if (ct_valid)
    begin
      assert (!valid_seen)
      else
        report_failure("ct_valid stayed high for more than one cycle");
      assert (exp_ct_q.size() != 0)
      else
        report_failure("ct_valid pulsed with no block outstanding");
      if (exp_ct_q.size() != 0)
      begin
        exp_ct   = exp_ct_q.pop_front();
        exp_edge = exp_edge_q.pop_front();
        assert (ciphertext == exp_ct)
        else
        begin
          $display("[ERROR] %0t ciphertext expected %h got %h", $time, exp_ct, ciphertext);
          errors++;
        end
        assert (cycle == exp_edge)
        else
        begin
          $display("[ERROR] %0t ct_valid edge expected %0d got %0d", $time, exp_edge, cycle);
          errors++;
        end
      end
    end
    valid_seen = ct_valid;
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  function automatic des_pkg::block_t rand_block();
    return {$urandom(), $urandom()};
  endfunction

  task automatic load_feedback(input des_pkg::block_t value);
    load_iv  = 1'b1;
    iv       = value;
    tick();
    load_iv  = 1'b0;
    model_fb = value;
  endtask

  task automatic issue_block(input des_pkg::block_t key, input des_pkg::block_t msg);
    des_pkg::block_t ks;
    des_pkg::block_t ct;
    ref_ofb_block(model_fb, key, msg, ks, ct);
    exp_ct_q.push_back(ct);
    // start is sampled on the next edge, ct_valid rises LATENCY edges later
    exp_edge_q.push_back(cycle + 1 + LATENCY);
    model_fb    = ks;
    start       = 1'b1;
    req.message = msg;
    req.key     = key;
    tick();
    start = 1'b0;
  endtask

  task automatic wait_blocks();
    while (exp_ct_q.size() != 0)
      tick();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before)
    begin
      tests_passed++;
      $display("%0t %s: pass", $time, name);
    end
    else
    begin
      tests_failed++;
      $display("%0t %s: fail, %0d errors", $time, name, errors - errors_before);
    end
  endtask

  initial
  begin
    int              err0;
    des_pkg::block_t ks;
    des_pkg::block_t ct;
    des_pkg::block_t key;
    void'($urandom(32'hccb4_fa8c));
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    req          = '0;
    load_iv      = 1'b0;
    iv           = '0;
    model_fb     = '0;
    cycle        = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    valid_seen   = 1'b0;
    idle(2);
    rst_n = 1'b1;
    tick();

    // classic DES vector, so decrypting 85e8...b405 gives 0123...cdef
    err0 = errors;
    ref_ofb_block(64'h85e8_1354_0f0a_b405, KAT_KEY, '0, ks, ct);
    assert (ks == 64'h0123_4567_89ab_cdef)
    else
    begin
      $display("[ERROR] %0t keystream expected %h got %h", $time,
               64'h0123_4567_89ab_cdef, ks);
      errors++;
    end
    load_feedback(64'h85e8_1354_0f0a_b405);
    issue_block(KAT_KEY, '0);
    wait_blocks();
    finish_test("known_answer", err0);

    err0 = errors;
    for (int i = 0; i < 20; i++)
    begin
      load_feedback(rand_block());
      issue_block(rand_block(), rand_block());
      wait_blocks();
    end
    finish_test("random_blocks", err0);

    err0 = errors;
    key  = rand_block();
    load_feedback(rand_block());
    for (int i = 0; i < 8; i++)
    begin
      issue_block(key, rand_block());
      wait_blocks();
    end
    finish_test("ofb_chaining", err0);

    err0 = errors;
    issue_block(key, rand_block());
    wait_blocks();
    finish_test("latency", err0);

    err0 = errors;
    issue_block(key, rand_block());
    idle(4);
    start = 1'b1;
    req   = {rand_block(), rand_block()};
    tick();
    start = 1'b0;
    // the iv strobe lands on the edge that ends the block
    idle(LATENCY - 6);
    load_iv = 1'b1;
    iv      = rand_block();
    tick();
    load_iv = 1'b0;
    wait_blocks();
    // any pulse from an ignored strobe would show up here
    idle(LATENCY + 4);
    issue_block(key, rand_block());
    wait_blocks();
    // with the engine idle the iv wins over a start in the same cycle
    start   = 1'b1;
    load_iv = 1'b1;
    iv      = rand_block();
    req     = {rand_block(), rand_block()};
    tick();
    start    = 1'b0;
    load_iv  = 1'b0;
    model_fb = iv;
    idle(LATENCY + 4);
    issue_block(key, rand_block());
    wait_blocks();
    finish_test("busy_strobes", err0);

    err0 = errors;
    load_feedback(rand_block());
    issue_block(key, rand_block());
    idle(6);
    rst_n = 1'b0;
    idle(2);
    rst_n = 1'b1;
    exp_ct_q.delete();
    exp_edge_q.delete();
    model_fb = '0;
    idle(LATENCY + 4);
    issue_block(key, rand_block());
    wait_blocks();
    finish_test("mid_block_reset", err0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+dv
src/des_pkg.sv
src/des_f_function.sv
src/des_key_schedule.sv
src/des_round_engine.sv
src/ofb_input_stage.sv
src/ofb_output_stage.sv
src/ofb_des_top.sv
dv/ofb_des_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the OFB DES testbench with Verilator, run from the project root
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module ofb_des_tb -Mdir obj_dir -o ofb_des_sim &&
./obj_dir/ofb_des_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^Test OK$' sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
